//--- common/pcs_types_pkg.sv
package pcs_types_pkg;

    // Widths of the receive datapath
    localparam int WORD_W   = 32;
    localparam int HEADER_W = 2;
    localparam int GB_SEQ_W = 7;

    // Half of a 64-bit block payload
    typedef logic [WORD_W-1:0] word_t;

    // Sync header in front of each 66-bit block
    typedef logic [HEADER_W-1:0] header_t;

    // Gearbox step, counts 0 to 32
    typedef logic [GB_SEQ_W-1:0] gb_seq_t;

    // Last step of the 33-cycle gearbox sequence
    localparam gb_seq_t GB_SEQ_MAX = gb_seq_t'(32);

endpackage

//--- common/pcs_proto_pkg.sv
package pcs_proto_pkg;

    import pcs_types_pkg::*;

    // Legal sync headers, anything else is a framing error
    localparam header_t SYNC_DATA = 2'b01;
    localparam header_t SYNC_CTRL = 2'b10;

    // Taps of x^58 + x^39 + 1, newest bit at history position 0
    localparam int SCR_TAP_A = 38;
    localparam int SCR_TAP_B = 57;

endpackage

//--- rx_gearbox/rx_gearbox.sv
module rx_gearbox
    import pcs_types_pkg::*;
#(
    parameter bit REGISTER_OUTPUT = 1'b1
) (
    input  logic    i_clk,
    input  logic    i_reset,
    input  word_t   i_data,
    input  logic    i_slip,
    output word_t   o_data,
    output header_t o_header,
    output logic    o_data_valid,
    output logic    o_header_valid
);

    // One full block, the buffer keeps one spare bit below it
    localparam int BUF_W = 2 * WORD_W + HEADER_W;
    localparam int IDX_W = $clog2(BUF_W + 1);

    gb_seq_t          gb_seq;
    logic             half_slip;
    logic             block_done;
    logic [IDX_W-1:0] load_idx;
    logic [IDX_W-1:0] data_start;
    logic [BUF_W:0]   asm_buf;
    logic [BUF_W:0]   next_buf;

    word_t   data_int;
    header_t header_int;
    logic    data_valid_int;
    logic    header_valid_int;

    // Load-index table of the 33 steps
    // Odd steps fill the upper half, even steps close the block
    function automatic logic [IDX_W-1:0] load_index(input gb_seq_t seq);
        if (seq == '0) begin
            return '0;
        end else if (seq[0]) begin
            return IDX_W'(WORD_W + 1 - int'(seq));
        end else begin
            return IDX_W'(BUF_W - int'(seq));
        end
    endfunction

    // Sequence stalls for one cycle on each slip
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            gb_seq    <= '0;
            half_slip <= 1'b0;
        end else if (i_slip) begin
            half_slip <= ~half_slip;
        end else begin
            gb_seq <= (gb_seq == GB_SEQ_MAX) ? '0 : gb_seq + 1'b1;
        end
    end

    assign block_done = ~gb_seq[0];
    assign load_idx   = load_index(gb_seq);

    always_comb begin
        next_buf = asm_buf;
        for (int i = 0; i < BUF_W; i++) begin
            if (block_done) begin
                // Tail of the current block on top, start of the next from bit 1
                if (gb_seq != '0 && i >= load_idx) begin
                    next_buf[i + 1] = i_data[i - load_idx];
                end else if (i < WORD_W - gb_seq) begin
                    next_buf[i + 1] = i_data[i + gb_seq];
                end
            end else if (i >= load_idx && i < load_idx + WORD_W) begin
                next_buf[i + 1] = i_data[i - load_idx];
            end
        end
        // Spare bit is the last bit of the block before
        if (block_done) begin
            next_buf[0] = next_buf[BUF_W];
        end
    end

    always_ff @(posedge i_clk) begin
        asm_buf <= next_buf;
    end

    // Extraction window, shifted down one bit while half_slip is set
    assign data_start = IDX_W'(HEADER_W + 1) + (block_done ? IDX_W'(WORD_W) : '0)
                        - IDX_W'(half_slip);

    assign data_int         = next_buf[data_start +: WORD_W];
    assign header_int       = next_buf[!half_slip +: HEADER_W];
    assign data_valid_int   = (gb_seq != '0);
    assign header_valid_int = gb_seq[0];

    if (REGISTER_OUTPUT) begin : g_reg_out
        always_ff @(posedge i_clk) begin
            if (i_reset) begin
                o_data_valid   <= 1'b0;
                o_header_valid <= 1'b0;
            end else begin
                o_data_valid   <= data_valid_int;
                o_header_valid <= header_valid_int;
            end
        end

        // Hold the last value between strobes
        always_ff @(posedge i_clk) begin
            if (data_valid_int) begin
                o_data <= data_int;
            end
            if (header_valid_int) begin
                o_header <= header_int;
            end
        end
    end else begin : g_comb_out
        assign o_data         = data_int;
        assign o_header       = header_int;
        assign o_data_valid   = data_valid_int;
        assign o_header_valid = header_valid_int;
    end

endmodule

//--- hdl/block_lock.sv
module block_lock
    import pcs_types_pkg::*;
    import pcs_proto_pkg::*;
#(
    parameter int LOCK_COUNT = 64,
    parameter int BAD_LIMIT  = 16,
    parameter int WINDOW     = 64
) (
    input  logic    i_clk,
    input  logic    i_reset,
    input  header_t i_header,
    input  logic    i_header_valid,
    output logic    o_slip,
    output logic    o_block_lock
);

    localparam int GOOD_W = $clog2(LOCK_COUNT + 1);
    localparam int BAD_W  = $clog2(BAD_LIMIT + 1);
    localparam int WIN_W  = $clog2(WINDOW + 1);

    typedef enum logic [1:0] {
        HUNT,
        SLIP_WAIT,
        LOCKED
    } lock_state_t;

    lock_state_t       state;
    logic [GOOD_W-1:0] good_cnt;
    logic [BAD_W-1:0]  bad_cnt;
    logic [WIN_W-1:0]  win_cnt;
    logic              skip_cnt;
    logic              header_ok;

    assign header_ok = (i_header == SYNC_DATA) || (i_header == SYNC_CTRL);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= HUNT;
            good_cnt     <= '0;
            bad_cnt      <= '0;
            win_cnt      <= '0;
            skip_cnt     <= 1'b0;
            o_slip       <= 1'b0;
            o_block_lock <= 1'b0;
        end else begin
            o_slip <= 1'b0;
            if (i_header_valid) begin
                case (state)
                    HUNT: begin
                        if (!header_ok) begin
                            o_slip   <= 1'b1;
                            good_cnt <= '0;
                            skip_cnt <= 1'b0;
                            state    <= SLIP_WAIT;
                        end else if (good_cnt == GOOD_W'(LOCK_COUNT - 1)) begin
                            good_cnt     <= '0;
                            bad_cnt      <= '0;
                            win_cnt      <= '0;
                            o_block_lock <= 1'b1;
                            state        <= LOCKED;
                        end else begin
                            good_cnt <= good_cnt + 1'b1;
                        end
                    end
                    // Gearbox needs two headers to settle after a slip
                    SLIP_WAIT: begin
                        skip_cnt <= 1'b1;
                        if (skip_cnt) begin
                            state <= HUNT;
                        end
                    end
                    LOCKED: begin
                        if (!header_ok && bad_cnt == BAD_W'(BAD_LIMIT - 1)) begin
                            o_block_lock <= 1'b0;
                            o_slip       <= 1'b1;
                            skip_cnt     <= 1'b0;
                            state        <= SLIP_WAIT;
                        end else if (win_cnt == WIN_W'(WINDOW - 1)) begin
                            // New window starts clean
                            win_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            win_cnt <= win_cnt + 1'b1;
                            if (!header_ok) begin
                                bad_cnt <= bad_cnt + 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= HUNT;
                    end
                endcase
            end
        end
    end

endmodule

//--- hdl/rx_descrambler.sv
module rx_descrambler
    import pcs_types_pkg::*;
    import pcs_proto_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  word_t   i_data,
    input  logic    i_data_valid,
    input  header_t i_header,
    input  logic    i_header_valid,
    output word_t   o_data,
    output logic    o_data_valid,
    output header_t o_header,
    output logic    o_header_valid
);

    localparam int HIST_W = SCR_TAP_B + 1;

    logic [HIST_W-1:0] scr_hist;
    logic [HIST_W-1:0] next_hist;
    word_t             descr_data;

    // Bit 0 first, received bits feed the history
    always_comb begin
        next_hist = scr_hist;
        for (int i = 0; i < WORD_W; i++) begin
            descr_data[i] = i_data[i] ^ next_hist[SCR_TAP_A] ^ next_hist[SCR_TAP_B];
            next_hist     = {next_hist[HIST_W-2:0], i_data[i]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_data_valid) begin
            scr_hist <= next_hist;
            o_data   <= descr_data;
        end
        // Header is not scrambled
        o_header <= i_header;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_data_valid   <= 1'b0;
            o_header_valid <= 1'b0;
        end else begin
            o_data_valid   <= i_data_valid;
            o_header_valid <= i_header_valid;
        end
    end

endmodule

//--- hdl/pcs_rx.sv
module pcs_rx
    import pcs_types_pkg::*;
#(
    parameter bit REGISTER_OUTPUT = 1'b1,
    parameter int LOCK_COUNT      = 64,
    parameter int BAD_LIMIT       = 16,
    parameter int WINDOW          = 64
) (
    input  logic    i_clk,
    input  logic    i_reset,
    input  word_t   i_data,
    output word_t   o_data,
    output logic    o_data_valid,
    output header_t o_header,
    output logic    o_header_valid,
    output logic    o_block_lock
);

    word_t   gb_data;
    logic    gb_data_valid;
    header_t gb_header;
    logic    gb_header_valid;
    logic    slip;

    rx_gearbox #(
        .REGISTER_OUTPUT (REGISTER_OUTPUT)
    ) u_rx_gearbox (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_data         (i_data),
        .i_slip         (slip),
        .o_data         (gb_data),
        .o_header       (gb_header),
        .o_data_valid   (gb_data_valid),
        .o_header_valid (gb_header_valid)
    );

    // Slip pulses go back to the gearbox until the headers line up
    block_lock #(
        .LOCK_COUNT (LOCK_COUNT),
        .BAD_LIMIT  (BAD_LIMIT),
        .WINDOW     (WINDOW)
    ) u_block_lock (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_header       (gb_header),
        .i_header_valid (gb_header_valid),
        .o_slip         (slip),
        .o_block_lock   (o_block_lock)
    );

    rx_descrambler u_rx_descrambler (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_data         (gb_data),
        .i_data_valid   (gb_data_valid),
        .i_header       (gb_header),
        .i_header_valid (gb_header_valid),
        .o_data         (o_data),
        .o_data_valid   (o_data_valid),
        .o_header       (o_header),
        .o_header_valid (o_header_valid)
    );

endmodule

//--- verification/pcs_rx_tb.sv
module pcs_rx_tb
    import pcs_types_pkg::*;
    import pcs_proto_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BLOCK_W      = 66;
    localparam int LOCK_COUNT   = 64;
    localparam int BAD_LIMIT    = 16;
    localparam int WINDOW       = 64;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TRIALS   = 4;
    localparam int CHECK_BLOCKS = 40;
    localparam int LOCK_HEADERS = 66 * 70;

    logic    i_clk;
    logic    i_reset;
    word_t   i_data;
    word_t   o_data;
    logic    o_data_valid;
    header_t o_header;
    logic    o_header_valid;
    logic    o_block_lock;

    // Transmit model
    logic        tx_bits[$];
    logic [57:0] tx_scr;
    word_t       tx_n;
    int          corrupt_left;

    logic [31:0] rng_state;
    int          error_count;
    int          blocks_checked;
    logic        check_enable;

    // Compare process state
    logic               framed;
    int                 dv_count;
    int                 skip_left;
    logic               have_n;
    logic               high_pending;
    word_t              exp_n;
    logic [BLOCK_W-1:0] exp_block;

    pcs_rx #(
        .REGISTER_OUTPUT (1'b1),
        .LOCK_COUNT      (LOCK_COUNT),
        .BAD_LIMIT       (BAD_LIMIT),
        .WINDOW          (WINDOW)
    ) u_dut (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_data         (i_data),
        .o_data         (o_data),
        .o_data_valid   (o_data_valid),
        .o_header       (o_header),
        .o_header_valid (o_header_valid),
        .o_block_lock   (o_block_lock)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Block n: header from the parity of n, payload n low and ~n high
    function automatic logic [BLOCK_W-1:0] expected_block(input word_t n);
        header_t hdr;
        hdr = n[0] ? SYNC_CTRL : SYNC_DATA;
        return {~n, n, hdr};
    endfunction

    task automatic stop_run();
        error_count++;
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("Error at time %0d ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED time %0d ns %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_header(input string name, input header_t exp, input header_t act);
        if (act !== exp) begin
            $display("FAILED time %0d ns %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED time %0d ns %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED time %0d ns %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    // Header as is, payload through x^58 + x^39 + 1, bit 0 first
    task automatic append_block();
        logic [BLOCK_W-1:0] blk;
        logic               sb;
        blk = expected_block(tx_n);
        if (corrupt_left > 0) begin
            blk[1:0] = 2'b11;
            corrupt_left--;
        end
        for (int i = 0; i < BLOCK_W; i++) begin
            if (i < HEADER_W) begin
                sb = blk[i];
            end else begin
                sb = blk[i] ^ tx_scr[SCR_TAP_A] ^ tx_scr[SCR_TAP_B];
                tx_scr = {tx_scr[56:0], sb};
            end
            tx_bits.push_back(sb);
        end
        tx_n = tx_n + 1'b1;
    endtask

    task automatic next_tx_word(output word_t w);
        while (tx_bits.size() < WORD_W) begin
            append_block();
        end
        for (int i = 0; i < WORD_W; i++) begin
            w[i] = tx_bits.pop_front();
        end
    endtask

    // Filler bits in front of the first block set the bit offset
    task automatic restart_tx(input int offset, input word_t first_n);
        tx_bits.delete();
        for (int i = 0; i < offset; i++) begin
            tx_bits.push_back(1'b0);
        end
        tx_scr[31:0]  = next_random();
        tx_scr[57:32] = 26'(next_random() >> 6);
        tx_n          = first_n;
        corrupt_left  = 0;
    endtask

    task automatic check_idle_outputs();
        check_bit("o_data_valid", 1'b0, o_data_valid);
        check_bit("o_header_valid", 1'b0, o_header_valid);
        check_bit("o_block_lock", 1'b0, o_block_lock);
    endtask

    task automatic reset_and_restart(input int offset);
        @(posedge i_clk);
        restart_tx(offset, next_random());
        check_enable = 1'b0;
        #1;
        i_reset = 1'b1;
        for (int cyc = 0; cyc < RESET_CYCLES; cyc++) begin
            @(posedge i_clk);
            if (cyc < RESET_CYCLES - 1) begin
                @(negedge i_clk);
                check_idle_outputs();
            end
        end
        #1;
        i_reset = 1'b0;
        @(negedge i_clk);
        check_idle_outputs();
    endtask

    task automatic wait_lock_state(input logic level, input int max_headers);
        int headers;
        int cycles;
        headers = 0;
        cycles  = 0;
        while (o_block_lock !== level) begin
            if (headers > max_headers || cycles > 4 * max_headers) begin
                report_failure($sformatf("o_block_lock never went to %b within %0d headers",
                                         level, max_headers));
            end
            @(negedge i_clk);
            cycles++;
            if (o_header_valid === 1'b1) begin
                headers++;
            end
        end
    endtask

    task automatic wait_blocks_checked(input int count);
        int cycles;
        cycles = 0;
        while (blocks_checked < count) begin
            if (cycles > 5 * (count + 4)) begin
                report_failure($sformatf("only %0d of %0d blocks reached the output",
                                         blocks_checked, count));
            end
            @(posedge i_clk);
            cycles++;
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial begin
        word_t w;
        forever begin
            @(posedge i_clk);
            #1;
            next_tx_word(w);
            i_data <= w;
        end
    end

    // Framing and data compare, sampled mid-cycle
    always @(negedge i_clk) begin
        if (i_reset || o_block_lock !== 1'b1) begin
            framed   = 1'b0;
            dv_count = 0;
        end else begin
            if (o_header_valid) begin
                if (framed) begin
                    check_count("o_data_valid words per block", 2, dv_count);
                end
                framed   = 1'b1;
                dv_count = 0;
            end
            if (o_data_valid) begin
                dv_count++;
            end
        end
        if (i_reset || o_block_lock !== 1'b1 || !check_enable) begin
            // Two blocks of settling for the descrambler history
            skip_left    = 2;
            have_n       = 1'b0;
            high_pending = 1'b0;
        end else if (o_header_valid) begin
            if (skip_left > 0) begin
                skip_left--;
            end else begin
                exp_n        = have_n ? exp_n + 1'b1 : o_data;
                have_n       = 1'b1;
                exp_block    = expected_block(exp_n);
                check_bit("o_data_valid", 1'b1, o_data_valid);
                check_header("o_header", exp_block[1:0], o_header);
                check_word("o_data", exp_block[33:2], o_data);
                high_pending = 1'b1;
            end
        end else if (o_data_valid && high_pending) begin
            check_word("o_data", exp_block[65:34], o_data);
            high_pending = 1'b0;
            blocks_checked++;
        end
    end

    initial begin
        int offset;
        int delay;
        i_reset        = 1'b1;
        i_data         = '0;
        rng_state      = 32'd90773;
        tx_scr         = '0;
        tx_n           = '0;
        corrupt_left   = 0;
        error_count    = 0;
        blocks_checked = 0;
        check_enable   = 1'b0;

        for (int trial = 0; trial < NUM_TRIALS; trial++) begin
            offset = int'(next_random() % BLOCK_W);
            $display("Trial %0d with stream bit offset %0d", trial, offset);
            reset_and_restart(offset);
            wait_lock_state(1'b1, LOCK_HEADERS);
            @(posedge i_clk);
            blocks_checked = 0;
            check_enable   = 1'b1;
            wait_blocks_checked(CHECK_BLOCKS);
        end

        // Bad headers drop lock, clean data brings it back
        delay = int'(next_random() % 32);
        repeat (delay) begin
            @(posedge i_clk);
        end
        check_enable = 1'b0;
        // A run of 2 x BAD_LIMIT leaves BAD_LIMIT in one window wherever its edge falls
        corrupt_left = 2 * BAD_LIMIT;
        wait_lock_state(1'b0, WINDOW);
        wait_lock_state(1'b1, LOCK_HEADERS);
        @(posedge i_clk);
        blocks_checked = 0;
        check_enable   = 1'b1;
        wait_blocks_checked(CHECK_BLOCKS);

        if (error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "Simulation ended with errors");
        end
    end

endmodule

//--- pcs_rx.f
common/pcs_types_pkg.sv
common/pcs_proto_pkg.sv
rx_gearbox/rx_gearbox.sv
hdl/block_lock.sv
hdl/rx_descrambler.sv
hdl/pcs_rx.sv
verification/pcs_rx_tb.sv

//--- Bender.yml
package:
  name: pcs_rx

sources:
  - common/pcs_types_pkg.sv
  - common/pcs_proto_pkg.sv
  - rx_gearbox/rx_gearbox.sv
  - hdl/block_lock.sv
  - hdl/rx_descrambler.sv
  - hdl/pcs_rx.sv
  - target: simulation
    files:
      - verification/pcs_rx_tb.sv
